// ==== verilog/mxint_pkg.sv ====
package mxint_pkg;

  // Input block format.
  localparam int IN_MAN_WIDTH = 8;
  localparam int IN_MAN_FRAC_WIDTH = 7;
  localparam int IN_EXP_WIDTH = 8;

  // Output block format.
  localparam int OUT_MAN_WIDTH = 4;
  localparam int OUT_MAN_FRAC_WIDTH = 3;
  localparam int OUT_EXP_WIDTH = 8;

  // Guard bits kept below the output LSB until rounding.
  localparam int ROUND_BITS = 4;
  localparam int CAST_WIDTH = OUT_MAN_WIDTH + ROUND_BITS;

  // Holds floor log2 of an 8-bit magnitude, 0 to 7.
  localparam int LOG2_WIDTH = 4;

  typedef logic signed [IN_MAN_WIDTH-1:0] in_man_t;
  typedef logic signed [IN_EXP_WIDTH-1:0] in_exp_t;

  typedef logic signed [OUT_MAN_WIDTH-1:0] out_man_t;
  typedef logic signed [OUT_EXP_WIDTH-1:0] out_exp_t;

  typedef logic [LOG2_WIDTH-1:0] log2_t;

  // Mantissa after the shift, before rounding.
  typedef logic signed [CAST_WIDTH-1:0] cast_t;

endpackage

// ==== verilog/mxint_block_scan.sv ====
`timescale 1ns/100ps

module mxint_block_scan #(
  parameter int BLOCK_SIZE = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  mxint_pkg::in_man_t man_in [BLOCK_SIZE],
  input  mxint_pkg::in_exp_t exp_in,
  input  logic              in_valid,
  output logic              in_ready,
  output mxint_pkg::in_man_t scan_man [BLOCK_SIZE],
  output mxint_pkg::in_exp_t scan_exp,
  output mxint_pkg::log2_t   scan_log2,
  output logic              scan_valid,
  input  logic              scan_ready
);
  import mxint_pkg::*;

  // Tree is padded to a power of two; unused leaves read as zero.
  localparam int LEVELS = $clog2(BLOCK_SIZE);
  localparam int LEAVES = 1 << LEVELS;

  logic [IN_MAN_WIDTH-1:0] mag [BLOCK_SIZE];
  logic [IN_MAN_WIDTH-1:0] node [1:2*LEAVES-1];
  log2_t                   max_log2;
  logic                    accept;

  // Magnitude fits unsigned, so -128 becomes 128.
  for (genvar i = 0; i < BLOCK_SIZE; i++) begin : g_mag
    assign mag[i] = man_in[i][IN_MAN_WIDTH-1] ? $unsigned(-man_in[i]) : $unsigned(man_in[i]);
  end

  for (genvar i = 0; i < LEAVES; i++) begin : g_leaf
    if (i < BLOCK_SIZE) begin : g_used
      assign node[LEAVES+i] = mag[i];
    end else begin : g_pad
      assign node[LEAVES+i] = '0;
    end
  end

  // Node k holds the larger of its two children; node 1 is the block maximum.
  for (genvar k = 1; k < LEAVES; k++) begin : g_node
    assign node[k] = (node[2*k] >= node[2*k+1]) ? node[2*k] : node[2*k+1];
  end

  // Position of the leading one; an all-zero block gives 0.
  always_comb begin
    max_log2 = '0;
    for (int b = 0; b < IN_MAN_WIDTH; b++) begin
      if (node[1][b]) begin
        max_log2 = log2_t'(b);
      end
    end
  end

  assign in_ready = !scan_valid || scan_ready;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      scan_valid <= 1'b0;
    end else if (in_ready) begin
      scan_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      scan_man  <= man_in;
      scan_exp  <= exp_in;
      scan_log2 <= max_log2;
    end
  end

  // A stalled block must stay put until the buffer takes it.
  a_scan_hold: assert property (
    @(posedge clk) disable iff (rst)
    scan_valid && !scan_ready |=> scan_valid && $stable(scan_exp) && $stable(scan_log2)
  );

  for (genvar i = 0; i < BLOCK_SIZE; i++) begin : g_hold
    a_scan_man_hold: assert property (
      @(posedge clk) disable iff (rst)
      scan_valid && !scan_ready |=> $stable(scan_man[i])
    );
  end

endmodule

// ==== verilog/mxint_requant.sv ====
`timescale 1ns/100ps

module mxint_requant #(
  parameter int BLOCK_SIZE = 4
) (
  input  mxint_pkg::in_man_t  scan_man [BLOCK_SIZE],
  input  mxint_pkg::in_exp_t  scan_exp,
  input  mxint_pkg::log2_t    scan_log2,
  output mxint_pkg::out_man_t req_man [BLOCK_SIZE],
  output mxint_pkg::out_exp_t req_exp
);
  import mxint_pkg::*;

  // Exponent arithmetic is done at 10 bits so nothing wraps before the clamp.
  localparam int EXP_FULL_W = 10;
  localparam int WIDE_W = IN_MAN_WIDTH + CAST_WIDTH;

  localparam logic signed [EXP_FULL_W-1:0] EXP_MAX = EXP_FULL_W'(2 ** (OUT_EXP_WIDTH - 1) - 1);
  localparam logic signed [EXP_FULL_W-1:0] EXP_MIN = EXP_FULL_W'(-(2 ** (OUT_EXP_WIDTH - 1)));

  localparam logic signed [EXP_FULL_W-1:0] SHIFT_ADJ =
    EXP_FULL_W'(OUT_MAN_FRAC_WIDTH + ROUND_BITS - IN_MAN_FRAC_WIDTH);

  localparam logic signed [WIDE_W-1:0] CAST_MAX = WIDE_W'(2 ** (CAST_WIDTH - 1) - 1);
  localparam logic signed [WIDE_W-1:0] CAST_MIN = WIDE_W'(-(2 ** (CAST_WIDTH - 1)));

  localparam logic signed [CAST_WIDTH:0] OUT_MAX = (CAST_WIDTH + 1)'(2 ** (OUT_MAN_WIDTH - 1) - 1);
  localparam logic signed [CAST_WIDTH:0] OUT_MIN = (CAST_WIDTH + 1)'(-(2 ** (OUT_MAN_WIDTH - 1)));

  // Half of one output LSB at the cast scale.
  localparam logic signed [CAST_WIDTH:0] HALF_LSB = (CAST_WIDTH + 1)'(2 ** (ROUND_BITS - 1));

  logic signed [EXP_FULL_W-1:0] exp_full;
  logic signed [EXP_FULL_W-1:0] shift;
  logic                         shift_neg;
  logic [LOG2_WIDTH-1:0]        lshift_amt;
  logic [LOG2_WIDTH-1:0]        rshift_amt;

  assign exp_full = $signed({1'b0, scan_log2}) + scan_exp - EXP_FULL_W'(IN_MAN_FRAC_WIDTH);

  always_comb begin
    if (exp_full > EXP_MAX) begin
      req_exp = EXP_MAX[OUT_EXP_WIDTH-1:0];
    end else if (exp_full < EXP_MIN) begin
      req_exp = EXP_MIN[OUT_EXP_WIDTH-1:0];
    end else begin
      req_exp = exp_full[OUT_EXP_WIDTH-1:0];
    end
  end

  // Shift that moves the input scale onto the cast scale of the new exponent.
  assign shift     = scan_exp - req_exp + SHIFT_ADJ;
  assign shift_neg = shift[EXP_FULL_W-1];

  // Beyond CAST_WIDTH any nonzero value saturates anyway.
  always_comb begin
    if (shift_neg) begin
      lshift_amt = '0;
    end else if (shift > EXP_FULL_W'(CAST_WIDTH)) begin
      lshift_amt = LOG2_WIDTH'(CAST_WIDTH);
    end else begin
      lshift_amt = shift[LOG2_WIDTH-1:0];
    end
  end

  // Past IN_MAN_WIDTH-1 only the sign is left.
  always_comb begin
    if (!shift_neg) begin
      rshift_amt = '0;
    end else if (-shift > EXP_FULL_W'(IN_MAN_WIDTH - 1)) begin
      rshift_amt = LOG2_WIDTH'(IN_MAN_WIDTH - 1);
    end else begin
      rshift_amt = LOG2_WIDTH'(-shift);
    end
  end

  for (genvar i = 0; i < BLOCK_SIZE; i++) begin : g_elem
    logic signed [WIDE_W-1:0]     man_ext;
    logic signed [WIDE_W-1:0]     man_shifted;
    cast_t                        man_cast;
    logic signed [CAST_WIDTH:0]   man_biased;
    logic signed [CAST_WIDTH:0]   man_rounded;

    assign man_ext = WIDE_W'(scan_man[i]);

    // Arithmetic right shift floors negative values.
    assign man_shifted = shift_neg ? (man_ext >>> rshift_amt) : (man_ext <<< lshift_amt);

    always_comb begin
      if (man_shifted > CAST_MAX) begin
        man_cast = CAST_MAX[CAST_WIDTH-1:0];
      end else if (man_shifted < CAST_MIN) begin
        man_cast = CAST_MIN[CAST_WIDTH-1:0];
      end else begin
        man_cast = man_shifted[CAST_WIDTH-1:0];
      end
    end

    // Adding half an LSB and flooring rounds to nearest with ties toward plus infinity.
    assign man_biased  = (CAST_WIDTH + 1)'(man_cast) + HALF_LSB;
    assign man_rounded = man_biased >>> ROUND_BITS;

    always_comb begin
      if (man_rounded > OUT_MAX) begin
        req_man[i] = OUT_MAX[OUT_MAN_WIDTH-1:0];
      end else if (man_rounded < OUT_MIN) begin
        req_man[i] = OUT_MIN[OUT_MAN_WIDTH-1:0];
      end else begin
        req_man[i] = man_rounded[OUT_MAN_WIDTH-1:0];
      end
    end
  end

endmodule

// ==== verilog/mxint_skid_buffer.sv ====
`timescale 1ns/100ps

module mxint_skid_buffer #(
  parameter int BLOCK_SIZE = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  mxint_pkg::out_man_t req_man [BLOCK_SIZE],
  input  mxint_pkg::out_exp_t req_exp,
  input  logic                scan_valid,
  output logic                scan_ready,
  output mxint_pkg::out_man_t man_out [BLOCK_SIZE],
  output mxint_pkg::out_exp_t exp_out,
  output logic                out_valid,
  input  logic                out_ready
);
  import mxint_pkg::*;

  out_man_t skid_man [BLOCK_SIZE];
  out_exp_t skid_exp;
  logic     skid_valid;
  logic     main_load;
  logic     skid_load;

  // Only a full skid register blocks the input.
  assign scan_ready = !skid_valid;

  // Main register is free when empty or being drained this cycle.
  assign main_load = !out_valid || out_ready;
  assign skid_load = !main_load && scan_valid && scan_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (main_load) begin
        out_valid  <= skid_valid || scan_valid;
        skid_valid <= 1'b0;
      end else if (skid_load) begin
        skid_valid <= 1'b1;
      end
    end
  end

  // Older block in the skid register goes out before the new one.
  always_ff @(posedge clk) begin
    if (main_load) begin
      man_out <= skid_valid ? skid_man : req_man;
      exp_out <= skid_valid ? skid_exp : req_exp;
    end
    if (skid_load) begin
      skid_man <= req_man;
      skid_exp <= req_exp;
    end
  end

  // The skid register only ever holds the second of two entries.
  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst)
    skid_valid |-> out_valid
  );

  a_out_hold: assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(exp_out)
  );

  for (genvar i = 0; i < BLOCK_SIZE; i++) begin : g_hold
    a_out_man_hold: assert property (
      @(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> $stable(man_out[i])
    );
  end

endmodule

// ==== verilog/mxint_cast.sv ====
`timescale 1ns/100ps

module mxint_cast #(
  parameter int BLOCK_SIZE = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  mxint_pkg::in_man_t  man_in [BLOCK_SIZE],
  input  mxint_pkg::in_exp_t  exp_in,
  input  logic                in_valid,
  output logic                in_ready,
  output mxint_pkg::out_man_t man_out [BLOCK_SIZE],
  output mxint_pkg::out_exp_t exp_out,
  output logic                out_valid,
  input  logic                out_ready
);
  import mxint_pkg::*;

  in_man_t  scan_man [BLOCK_SIZE];
  in_exp_t  scan_exp;
  log2_t    scan_log2;
  logic     scan_valid;
  logic     scan_ready;

  out_man_t req_man [BLOCK_SIZE];
  out_exp_t req_exp;

  mxint_block_scan #(
    .BLOCK_SIZE(BLOCK_SIZE)
  ) i_mxint_block_scan (
    .clk       (clk),
    .rst       (rst),
    .man_in    (man_in),
    .exp_in    (exp_in),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .scan_man  (scan_man),
    .scan_exp  (scan_exp),
    .scan_log2 (scan_log2),
    .scan_valid(scan_valid),
    .scan_ready(scan_ready)
  );

  // Requantization sits between the scanner register and the buffer.
  mxint_requant #(
    .BLOCK_SIZE(BLOCK_SIZE)
  ) i_mxint_requant (
    .scan_man (scan_man),
    .scan_exp (scan_exp),
    .scan_log2(scan_log2),
    .req_man  (req_man),
    .req_exp  (req_exp)
  );

  mxint_skid_buffer #(
    .BLOCK_SIZE(BLOCK_SIZE)
  ) i_mxint_skid_buffer (
    .clk       (clk),
    .rst       (rst),
    .req_man   (req_man),
    .req_exp   (req_exp),
    .scan_valid(scan_valid),
    .scan_ready(scan_ready),
    .man_out   (man_out),
    .exp_out   (exp_out),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

// ==== test/mxint_cast_tb.sv ====
`timescale 1ns/100ps

module mxint_cast_tb;
  import mxint_pkg::*;

  localparam int BLOCK_SIZE = 4;
  localparam int NUM_ROWS = 14;
  localparam int NUM_RANDOM = 200;
  localparam int TIMEOUT_CYCLES = 1000;
  localparam int READY_LEN = 4096;
  localparam int READY_HIGH = 0;
  localparam int READY_LOW = 1;
  localparam int READY_RANDOM = 2;
  localparam int CAST_MAX = 2 ** (CAST_WIDTH - 1) - 1;
  localparam int OUT_MAX = 2 ** (OUT_MAN_WIDTH - 1) - 1;

  logic     clk = 1'b0;
  logic     rst;
  in_man_t  man_in [BLOCK_SIZE];
  in_exp_t  exp_in;
  logic     in_valid;
  logic     in_ready;
  out_man_t man_out [BLOCK_SIZE];
  out_exp_t exp_out;
  logic     out_valid;
  logic     out_ready;

  // Each row holds four input mantissas, the input exponent, four output mantissas
  // and the output exponent.
  int rows [NUM_ROWS][10];

  in_man_t  next_man [BLOCK_SIZE];
  in_exp_t  next_exp;
  out_man_t next_ref_man [BLOCK_SIZE];
  out_exp_t next_ref_exp;

  logic [BLOCK_SIZE*OUT_MAN_WIDTH-1:0] exp_man_q [$];
  out_exp_t                            exp_exp_q [$];
  int                                  accept_q [$];

  logic [BLOCK_SIZE*OUT_MAN_WIDTH-1:0] mon_man;
  out_exp_t                            mon_exp;
  int                                  mon_acc;

  logic   ready_pattern [READY_LEN];
  int     ready_mode = READY_HIGH;
  int     mode_now;
  int     ready_idx = 0;
  int     cycle = 0;
  logic   latency_check = 1'b0;
  integer seed;
  int     man_errors = 0;
  int     exp_errors = 0;
  int     timeout_errors = 0;
  int     proto_errors = 0;

  mxint_cast #(
    .BLOCK_SIZE(BLOCK_SIZE)
  ) i_mxint_cast (
    .clk      (clk),
    .rst      (rst),
    .man_in   (man_in),
    .exp_in   (exp_in),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .man_out  (man_out),
    .exp_out  (exp_out),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Mode is sampled on the edge so a change made after the edge takes effect one cycle later.
  always @(posedge clk) begin
    mode_now = ready_mode;
    #2;
    if (mode_now == READY_RANDOM) begin
      out_ready = ready_pattern[ready_idx % READY_LEN];
      ready_idx++;
    end else begin
      out_ready = (mode_now == READY_HIGH);
    end
  end

  task automatic check_man(input string name, input out_man_t expected, input out_man_t actual);
    if (actual !== expected) begin
      man_errors++;
      $display("FAILED at %0t: %s expected %0d got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic check_exp(input string name, input out_exp_t expected, input out_exp_t actual);
    if (actual !== expected) begin
      exp_errors++;
      $display("FAILED at %0t: %s expected %0d got %0d", $time, name, expected, actual);
    end
  endtask

  // Shift onto the cast scale, saturate, add half an LSB, floor, saturate again.
  function automatic int scale_round(input int m, input int s);
    int c;
    int r;
    if (s >= 0) begin
      c = m * (2 ** s);
    end else begin
      c = m >>> (-s);
    end
    if (c > CAST_MAX) c = CAST_MAX;
    if (c < -CAST_MAX - 1) c = -CAST_MAX - 1;
    r = (c + 2 ** (ROUND_BITS - 1)) >>> ROUND_BITS;
    if (r > OUT_MAX) r = OUT_MAX;
    if (r < -OUT_MAX - 1) r = -OUT_MAX - 1;
    return r;
  endfunction

  function automatic void compute_expected();
    int mag;
    int max_mag;
    int lg;
    int e_out;
    int s;
    max_mag = 0;
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      mag = int'(next_man[i]);
      if (mag < 0) mag = -mag;
      if (mag > max_mag) max_mag = mag;
    end
    lg = 0;
    while ((2 << lg) <= max_mag) lg++;
    e_out = lg + int'(next_exp) - IN_MAN_FRAC_WIDTH;
    if (e_out > 127) e_out = 127;
    if (e_out < -128) e_out = -128;
    s = int'(next_exp) - IN_MAN_FRAC_WIDTH - e_out + OUT_MAN_FRAC_WIDTH + ROUND_BITS;
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      next_ref_man[i] = out_man_t'(scale_round(int'(next_man[i]), s));
    end
    next_ref_exp = out_exp_t'(e_out);
  endfunction

  // Called 2 ns after an edge; returns 2 ns after the edge that took the block.
  task automatic send_block();
    int waited;
    logic [BLOCK_SIZE*OUT_MAN_WIDTH-1:0] packed_man;
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      man_in[i] = next_man[i];
      packed_man[i*OUT_MAN_WIDTH +: OUT_MAN_WIDTH] = next_ref_man[i];
    end
    exp_in = next_exp;
    in_valid = 1'b1;
    waited = 0;
    @(negedge clk);
    while (in_ready !== 1'b1 && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (latency_check && waited != 0) begin
      proto_errors++;
      $display("Error at %0t: in_ready dropped while blocks streamed with the output ready",
               $time);
    end
    if (in_ready === 1'b1) begin
      exp_man_q.push_back(packed_man);
      exp_exp_q.push_back(next_ref_exp);
      accept_q.push_back(cycle);
    end else begin
      timeout_errors++;
      $display("Timeout at %0t: in_ready stayed low, input block never accepted", $time);
    end
    @(posedge clk);
    #2;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_man_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
      @(posedge clk);
      waited++;
    end
    if (exp_man_q.size() != 0) begin
      timeout_errors++;
      $display("Timeout at %0t: out_valid handshake stalled with %0d blocks pending",
               $time, exp_man_q.size());
    end
    #2;
  endtask

  // Outputs are stable at the falling edge; a transfer then happens on the next rising edge.
  always @(negedge clk) begin
    if (rst === 1'b0 && out_valid === 1'b1 && out_ready === 1'b1) begin
      if (exp_man_q.size() == 0) begin
        proto_errors++;
        $display("Error at %0t: output block appeared with no block pending", $time);
      end else begin
        mon_man = exp_man_q.pop_front();
        mon_exp = exp_exp_q.pop_front();
        mon_acc = accept_q.pop_front();
        for (int i = 0; i < BLOCK_SIZE; i++) begin
          check_man($sformatf("man_out[%0d]", i),
                    out_man_t'(mon_man[i*OUT_MAN_WIDTH +: OUT_MAN_WIDTH]), man_out[i]);
        end
        check_exp("exp_out", mon_exp, exp_out);
        if (latency_check && cycle - mon_acc != 2) begin
          proto_errors++;
          $display("Error at %0t: block left %0d cycles after it was offered, expected 2",
                   $time, cycle - mon_acc);
        end
      end
    end
  end

  initial begin
    seed = 14662;
    rst = 1'b1;
    in_valid = 1'b0;
    exp_in = '0;
    out_ready = 1'b1;
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      man_in[i] = '0;
    end
    for (int i = 0; i < READY_LEN; i++) begin
      ready_pattern[i] = (($random(seed) & 3) != 0);
    end
    rows = '{
      '{  64,   20,  -20,    3,    0,    7,  3, -2,  0,   -1},
      '{ 127,    0,    0,    0,    0,    7,  0,  0,  0,   -1},
      '{-128,   64,    1,   -1,    0,   -8,  4,  0,  0,    0},
      '{   0,    0,    0,    0,    5,    0,  0,  0,  0,   -2},
      '{-128,  100,  -50,    8,  127,   -8,  6, -3,  1,  127},
      '{   4,    7,   -5,    2, -128,    0,  0,  0,  0, -128},
      '{   1,   -1,    0,    1, -124,    1, -1,  0,  1, -128},
      '{   8,   -3,    5,    2, -125,    4, -1,  3,  1, -128},
      '{  96,    4,   -4,   12,    0,    7,  1,  0,  2,   -1},
      '{  16,  -16,   31,  -31,   10,    7, -8,  7, -8,    7},
      '{  32,   17,   -9,    0,   -3,    7,  4, -2,  0,   -5},
      '{   1,    0,   -1,    0,    1,    7,  0, -8,  0,   -6},
      '{   2,    3,   -2,   -3,   -1,    7,  7, -8, -8,   -7},
      '{-127,   63,  -64,    1,   -7,   -8,  7, -8,  0,   -8}
    };

    repeat (2) begin
      @(negedge clk);
      if (out_valid !== 1'b0) begin
        proto_errors++;
        $display("Error at %0t: out_valid is not low during reset", $time);
      end
    end
    @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
      proto_errors++;
      $display("Error at %0t: after reset out_valid must be low and in_ready high", $time);
    end
    @(posedge clk);
    #2;

    // Hand-worked blocks stream back to back with the output always ready.
    latency_check = 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int i = 0; i < BLOCK_SIZE; i++) begin
        next_man[i] = in_man_t'(rows[r][i]);
        next_ref_man[i] = out_man_t'(rows[r][5+i]);
      end
      next_exp = in_exp_t'(rows[r][4]);
      next_ref_exp = out_exp_t'(rows[r][9]);
      send_block();
    end
    wait_drain();
    latency_check = 1'b0;

    // The output stalls first so that three blocks fill the scanner and both buffer entries.
    ready_mode = READY_LOW;
    @(posedge clk);
    #2;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      for (int i = 0; i < BLOCK_SIZE; i++) begin
        next_man[i] = in_man_t'($random(seed)) >>> ($unsigned($random(seed)) % 8);
      end
      next_exp = in_exp_t'($random(seed));
      if (($random(seed) & 7) == 0) begin
        next_exp = in_exp_t'(-128 + ($random(seed) & 7));
      end
      compute_expected();
      send_block();
      if (n == 2) begin
        repeat (6) begin
          @(negedge clk);
          if (in_ready !== 1'b0) begin
            proto_errors++;
            $display("Error at %0t: in_ready high while scanner and buffer are full", $time);
          end
        end
        @(posedge clk);
        #2;
        ready_mode = READY_RANDOM;
      end
    end
    wait_drain();
    ready_mode = READY_HIGH;
    repeat (5) @(posedge clk);

    $display("Errors: mantissa %0d, exponent %0d, timeout %0d, handshake %0d",
             man_errors, exp_errors, timeout_errors, proto_errors);
    if (man_errors + exp_errors + timeout_errors + proto_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
verilog/mxint_pkg.sv
verilog/mxint_block_scan.sv
verilog/mxint_requant.sv
verilog/mxint_skid_buffer.sv
verilog/mxint_cast.sv
test/mxint_cast_tb.sv

// ==== Bender.yml ====
package:
  name: mxint_cast

sources:
  # Package first, then the stages, then the top level.
  - files:
      - verilog/mxint_pkg.sv
      - verilog/mxint_block_scan.sv
      - verilog/mxint_requant.sv
      - verilog/mxint_skid_buffer.sv
      - verilog/mxint_cast.sv

  - target: test
    files:
      - test/mxint_cast_tb.sv
